// File: source/netlink_pkg.sv
// netlink receive types
`default_nettype none

package netlink_pkg;

	// widths below assume eight bits per lane
	localparam int LANE_WORD_BITS = 8;
	localparam int FRAME_BITS = 32;
	localparam int TILE_BITS = 4;
	localparam int GARBAGE_BITS = 3;
	localparam int QUEUE_TILES = 6;

	// frame layout, lane 0 in the top byte
	localparam int SEQ_POS = 31;
	localparam int GARBAGE_MSB = 30;
	localparam int GARBAGE_LSB = 28;
	localparam int HOLD_MSB = 27;
	localparam int HOLD_LSB = 24;
	// tile 0 sits right below the hold tile
	localparam int QUEUE_MSB = 23;

	typedef logic [LANE_WORD_BITS-1:0] lane_word_t;
	typedef logic [FRAME_BITS-1:0] frame_t;
	typedef logic [TILE_BITS-1:0] tile_t;
	typedef logic [GARBAGE_BITS-1:0] garbage_t;
	typedef logic [3:0] frames_cnt_t;

	typedef enum logic [1:0] {IDLE, WAIT_START, SHIFT, DELIVER} seq_state_e;

endpackage

`default_nettype wire

// File: source/lane_deserializer.sv
// serial lane shift register
`timescale 1ns/1ps
`default_nettype none

module lane_deserializer #(
	parameter int LANE_BITS = 8
) (
	input  logic                   clk,
	input  logic                   rst_l,
	input  logic                   serial_in,
	input  logic                   shift_en,
	output netlink_pkg::lane_word_t lane_word
);

	logic [LANE_BITS-1:0] shift_q;

	// msb arrives first, so shift towards the top
	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			shift_q <= '0;
		end else if (shift_en) begin
			shift_q <= {shift_q[LANE_BITS-2:0], serial_in};
		end
	end

	// word stays put between frames for the checker
	assign lane_word = shift_q;

endmodule

`default_nettype wire

// File: source/bit_counter.sv
// data bit counter
`timescale 1ns/1ps
`default_nettype none

module bit_counter #(
	parameter int LANE_BITS = 8
) (
	input  logic clk,
	input  logic rst_l,
	input  logic count_en,
	output logic last_bit
);

	localparam int CNT_W = (LANE_BITS > 1) ? $clog2(LANE_BITS) : 1;

	logic [CNT_W-1:0] cnt_q;

	// clears whenever the sequencer leaves shift
	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			cnt_q <= '0;
		end else if (count_en) begin
			cnt_q <= cnt_q + 1'b1;
		end else begin
			cnt_q <= '0;
		end
	end

	// high while the final bit is on the lanes
	assign last_bit = count_en && (cnt_q == CNT_W'(LANE_BITS - 1));

endmodule

`default_nettype wire

// File: source/frame_sequencer.sv
// frame receive sequencer
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer #(
	parameter int LANE_BITS = 8
) (
	input  logic clk,
	input  logic rst_l,
	input  logic link_enable,
	input  logic start_bit,
	input  logic last_bit,
	output logic shift_en,
	output logic count_en,
	output logic frame_valid
);

	netlink_pkg::seq_state_e state_q;
	netlink_pkg::seq_state_e state_d;

	// lane words feed the frame layout directly
	if (LANE_BITS != $bits(netlink_pkg::lane_word_t)) begin : g_width_check
		$error("lane width does not match the frame layout");
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			netlink_pkg::IDLE: begin
				if (link_enable) state_d = netlink_pkg::WAIT_START;
			end
			netlink_pkg::WAIT_START: begin
				if (!link_enable) state_d = netlink_pkg::IDLE;
				else if (start_bit) state_d = netlink_pkg::SHIFT;
			end
			netlink_pkg::SHIFT: begin
				if (last_bit) state_d = netlink_pkg::DELIVER;
			end
			default: state_d = netlink_pkg::WAIT_START;
		endcase
	end

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			state_q <= netlink_pkg::IDLE;
			frame_valid <= 1'b0;
		end else begin
			state_q <= state_d;
			// one cycle after deliver, lane words are settled by then
			frame_valid <= (state_q == netlink_pkg::DELIVER);
		end
	end

	assign shift_en = (state_q == netlink_pkg::SHIFT);
	assign count_en = (state_q == netlink_pkg::SHIFT);

endmodule

`default_nettype wire

// File: source/frame_checker.sv
// frame check and opponent output
`timescale 1ns/1ps
`default_nettype none

module frame_checker (
	input  logic                     clk,
	input  logic                     rst_l,
	input  logic                     frame_valid,
	input  netlink_pkg::lane_word_t  lane_word_0,
	input  netlink_pkg::lane_word_t  lane_word_1,
	input  netlink_pkg::lane_word_t  lane_word_2,
	input  netlink_pkg::lane_word_t  lane_word_3,
	input  logic                     update_ready,
	output logic                     update_valid,
	output netlink_pkg::garbage_t    opp_garbage,
	output netlink_pkg::tile_t       opp_hold,
	output netlink_pkg::tile_t       opp_queue_0,
	output netlink_pkg::tile_t       opp_queue_1,
	output netlink_pkg::tile_t       opp_queue_2,
	output netlink_pkg::tile_t       opp_queue_3,
	output netlink_pkg::tile_t       opp_queue_4,
	output netlink_pkg::tile_t       opp_queue_5,
	output logic                     ack_send,
	output logic                     ack_seq,
	output netlink_pkg::frames_cnt_t frames_accepted
);

	netlink_pkg::frame_t frame;
	netlink_pkg::tile_t  queue_q [netlink_pkg::QUEUE_TILES];
	logic                expected_seq;
	logic                accept;

	assign frame = {lane_word_0, lane_word_1, lane_word_2, lane_word_3};

	// drop on a pending update or a repeated sequence bit
	assign accept = frame_valid && !update_valid &&
		(frame[netlink_pkg::SEQ_POS] == expected_seq);

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			update_valid <= 1'b0;
			ack_send <= 1'b0;
			ack_seq <= 1'b0;
			expected_seq <= 1'b0;
			frames_accepted <= '0;
		end else begin
			ack_send <= accept;
			if (accept) begin
				update_valid <= 1'b1;
				ack_seq <= frame[netlink_pkg::SEQ_POS];
				expected_seq <= ~expected_seq;
				frames_accepted <= frames_accepted + 1'b1;
			end else if (update_valid && update_ready) begin
				update_valid <= 1'b0;
			end
		end
	end

	// fields only change when a new update is raised
	always_ff @(posedge clk) begin
		if (accept) begin
			opp_garbage <= frame[netlink_pkg::GARBAGE_MSB:netlink_pkg::GARBAGE_LSB];
			opp_hold <= frame[netlink_pkg::HOLD_MSB:netlink_pkg::HOLD_LSB];
			for (int i = 0; i < netlink_pkg::QUEUE_TILES; i++) begin
				queue_q[i] <= frame[netlink_pkg::QUEUE_MSB - i * netlink_pkg::TILE_BITS -:
					netlink_pkg::TILE_BITS];
			end
		end
	end

	assign opp_queue_0 = queue_q[0];
	assign opp_queue_1 = queue_q[1];
	assign opp_queue_2 = queue_q[2];
	assign opp_queue_3 = queue_q[3];
	assign opp_queue_4 = queue_q[4];
	assign opp_queue_5 = queue_q[5];

endmodule

`default_nettype wire

// File: source/ack_decoder.sv
// acknowledge packet decoder
`timescale 1ns/1ps
`default_nettype none

module ack_decoder #(
	parameter int ACK_BITS = 4
) (
	input  logic clk,
	input  logic rst_l,
	input  logic serial_ack,
	output logic ack_received,
	output logic ack_rx_seq
);

	localparam int CNT_W = $clog2(ACK_BITS);

	logic                busy_q;
	logic                done_q;
	logic [CNT_W-1:0]    cnt_q;
	logic [ACK_BITS-1:0] shift_q;
	logic                pid_ok;

	// start bit opens the packet, last bit closes it
	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			cnt_q <= '0;
		end else begin
			done_q <= busy_q && (cnt_q == CNT_W'(ACK_BITS - 1));
			if (!busy_q) begin
				busy_q <= serial_ack;
				cnt_q <= '0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
				if (cnt_q == CNT_W'(ACK_BITS - 1)) busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (busy_q) shift_q <= {shift_q[ACK_BITS-2:0], serial_ack};
	end

	// pid first, then pid_n, then seq
	assign pid_ok = shift_q[ACK_BITS-1] && !shift_q[ACK_BITS-2];

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			ack_received <= 1'b0;
			ack_rx_seq <= 1'b0;
		end else begin
			ack_received <= done_q && pid_ok;
			if (done_q && pid_ok) ack_rx_seq <= shift_q[ACK_BITS-3];
		end
	end

endmodule

`default_nettype wire

// File: source/netlink_rx.sv
// netlink receiver top
`timescale 1ns/1ps
`default_nettype none

module netlink_rx #(
	parameter int LANE_BITS = 8,
	parameter int ACK_BITS = 4
) (
	input  logic                     clk,
	input  logic                     rst_l,
	input  logic                     link_enable,
	input  logic                     serial_ack,
	input  logic                     serial_data_0,
	input  logic                     serial_data_1,
	input  logic                     serial_data_2,
	input  logic                     serial_data_3,
	input  logic                     update_ready,
	output logic                     update_valid,
	output netlink_pkg::garbage_t    opp_garbage,
	output netlink_pkg::tile_t       opp_hold,
	output netlink_pkg::tile_t       opp_queue_0,
	output netlink_pkg::tile_t       opp_queue_1,
	output netlink_pkg::tile_t       opp_queue_2,
	output netlink_pkg::tile_t       opp_queue_3,
	output netlink_pkg::tile_t       opp_queue_4,
	output netlink_pkg::tile_t       opp_queue_5,
	output logic                     ack_send,
	output logic                     ack_seq,
	output netlink_pkg::frames_cnt_t frames_accepted,
	output logic                     ack_received,
	output logic                     ack_rx_seq
);

	logic shift_en;
	logic count_en;
	logic last_bit;
	logic frame_valid;
	netlink_pkg::lane_word_t lane_word_0;
	netlink_pkg::lane_word_t lane_word_1;
	netlink_pkg::lane_word_t lane_word_2;
	netlink_pkg::lane_word_t lane_word_3;

	// start bit is taken from lane 0 only
	frame_sequencer #(.LANE_BITS(LANE_BITS)) i_sequencer (
		.clk(clk), .rst_l(rst_l), .link_enable(link_enable), .start_bit(serial_data_0),
		.last_bit(last_bit), .shift_en(shift_en), .count_en(count_en),
		.frame_valid(frame_valid)
	);

	bit_counter #(.LANE_BITS(LANE_BITS)) i_bit_counter (
		.clk(clk), .rst_l(rst_l), .count_en(count_en), .last_bit(last_bit)
	);

	lane_deserializer #(.LANE_BITS(LANE_BITS)) i_lane_0 (
		.clk(clk), .rst_l(rst_l), .serial_in(serial_data_0), .shift_en(shift_en),
		.lane_word(lane_word_0)
	);
	lane_deserializer #(.LANE_BITS(LANE_BITS)) i_lane_1 (
		.clk(clk), .rst_l(rst_l), .serial_in(serial_data_1), .shift_en(shift_en),
		.lane_word(lane_word_1)
	);
	lane_deserializer #(.LANE_BITS(LANE_BITS)) i_lane_2 (
		.clk(clk), .rst_l(rst_l), .serial_in(serial_data_2), .shift_en(shift_en),
		.lane_word(lane_word_2)
	);
	lane_deserializer #(.LANE_BITS(LANE_BITS)) i_lane_3 (
		.clk(clk), .rst_l(rst_l), .serial_in(serial_data_3), .shift_en(shift_en),
		.lane_word(lane_word_3)
	);

	frame_checker i_checker (
		.clk(clk), .rst_l(rst_l), .frame_valid(frame_valid),
		.lane_word_0(lane_word_0), .lane_word_1(lane_word_1),
		.lane_word_2(lane_word_2), .lane_word_3(lane_word_3),
		.update_ready(update_ready), .update_valid(update_valid),
		.opp_garbage(opp_garbage), .opp_hold(opp_hold),
		.opp_queue_0(opp_queue_0), .opp_queue_1(opp_queue_1), .opp_queue_2(opp_queue_2),
		.opp_queue_3(opp_queue_3), .opp_queue_4(opp_queue_4), .opp_queue_5(opp_queue_5),
		.ack_send(ack_send), .ack_seq(ack_seq), .frames_accepted(frames_accepted)
	);

	ack_decoder #(.ACK_BITS(ACK_BITS)) i_ack_decoder (
		.clk(clk), .rst_l(rst_l), .serial_ack(serial_ack),
		.ack_received(ack_received), .ack_rx_seq(ack_rx_seq)
	);

endmodule

`default_nettype wire

// File: test/netlink_rx_sva.sv
// netlink receiver assertions
`timescale 1ns/1ps
`default_nettype none

module netlink_rx_sva (
	input  logic                     clk,
	input  logic                     rst_l,
	input  logic                     update_valid,
	input  logic                     update_ready,
	input  logic                     ack_send,
	input  logic                     ack_received,
	input  netlink_pkg::garbage_t    opp_garbage,
	input  netlink_pkg::tile_t       opp_hold,
	input  netlink_pkg::tile_t       opp_queue_0,
	input  netlink_pkg::tile_t       opp_queue_1,
	input  netlink_pkg::tile_t       opp_queue_2,
	input  netlink_pkg::tile_t       opp_queue_3,
	input  netlink_pkg::tile_t       opp_queue_4,
	input  netlink_pkg::tile_t       opp_queue_5
);

	logic [30:0] fields;

	assign fields = {opp_garbage, opp_hold, opp_queue_0, opp_queue_1, opp_queue_2,
		opp_queue_3, opp_queue_4, opp_queue_5};

	// both acknowledge outputs are single-cycle pulses
	assert property (@(posedge clk) disable iff (!rst_l) ack_send |=> !ack_send)
		else $error("ack_send stayed high for more than one cycle");
	assert property (@(posedge clk) disable iff (!rst_l) ack_received |=> !ack_received)
		else $error("ack_received stayed high for more than one cycle");

	// a waiting update keeps its fields
	assert property (@(posedge clk) disable iff (!rst_l)
		update_valid && !update_ready |=> update_valid && $stable(fields))
		else $error("opponent fields changed while the update was waiting");
	assert property (@(posedge clk) disable iff (!rst_l)
		update_valid && update_ready |=> !update_valid)
		else $error("update_valid still high after the transfer");

endmodule

bind netlink_rx netlink_rx_sva i_sva (
	.clk(clk), .rst_l(rst_l), .update_valid(update_valid), .update_ready(update_ready),
	.ack_send(ack_send), .ack_received(ack_received), .opp_garbage(opp_garbage),
	.opp_hold(opp_hold), .opp_queue_0(opp_queue_0), .opp_queue_1(opp_queue_1),
	.opp_queue_2(opp_queue_2), .opp_queue_3(opp_queue_3), .opp_queue_4(opp_queue_4),
	.opp_queue_5(opp_queue_5)
);

`default_nettype wire

// File: test/netlink_rx_tb.sv
// netlink receiver testbench
`timescale 1ns/1ps
`default_nettype none

module netlink_rx_tb;

	localparam int LANE_BITS = 8;
	localparam int ACK_BITS = 4;
	localparam logic [31:0] SEED = 32'h6e0a098a;
	localparam int N_SENDS = 240;
	localparam int N_ACKS = 150;
	// worst case cycles per loop pass, link drop included
	localparam int MAX_SPACING = 32;
	localparam int WATCHDOG_NS = N_SENDS * MAX_SPACING * 8 + 2000;

	logic clk;
	logic rst_l;
	logic link_enable;
	logic serial_ack;
	logic serial_data_0;
	logic serial_data_1;
	logic serial_data_2;
	logic serial_data_3;
	logic update_ready;
	logic update_valid;
	netlink_pkg::garbage_t opp_garbage;
	netlink_pkg::tile_t opp_hold;
	netlink_pkg::tile_t opp_queue [6];
	logic ack_send;
	logic ack_seq;
	netlink_pkg::frames_cnt_t frames_accepted;
	logic ack_received;
	logic ack_rx_seq;

	// model state
	int cyc = 0;
	int frame_start_q[$];
	netlink_pkg::frame_t frame_q[$];
	int ack_start_q[$];
	logic [2:0] ack_bits_q[$];
	logic m_valid = 1'b0;
	logic m_seq = 1'b0;
	logic m_loaded = 1'b0;
	logic m_ack_seq = 1'b0;
	logic m_rx_seq = 1'b0;
	logic last_accepted = 1'b0;
	netlink_pkg::frames_cnt_t m_count = '0;
	netlink_pkg::frame_t m_frame;
	int accepts = 0;
	int rejects = 0;
	int drops = 0;
	int good_acks = 0;

	netlink_rx #(.LANE_BITS(LANE_BITS), .ACK_BITS(ACK_BITS)) i_dut (
		.clk(clk), .rst_l(rst_l), .link_enable(link_enable), .serial_ack(serial_ack),
		.serial_data_0(serial_data_0), .serial_data_1(serial_data_1),
		.serial_data_2(serial_data_2), .serial_data_3(serial_data_3),
		.update_ready(update_ready), .update_valid(update_valid),
		.opp_garbage(opp_garbage), .opp_hold(opp_hold),
		.opp_queue_0(opp_queue[0]), .opp_queue_1(opp_queue[1]), .opp_queue_2(opp_queue[2]),
		.opp_queue_3(opp_queue[3]), .opp_queue_4(opp_queue[4]), .opp_queue_5(opp_queue[5]),
		.ack_send(ack_send), .ack_seq(ack_seq), .frames_accepted(frames_accepted),
		.ack_received(ack_received), .ack_rx_seq(ack_rx_seq)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "netlink_rx_tb stopped on the first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("[FAIL] %s got %h expected %h at cycle %0d",
				name, got, exp, cyc));
		end
	endtask

	task automatic check_tile(input string name, input netlink_pkg::tile_t got,
		input netlink_pkg::tile_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("[FAIL] %s got %h expected %h at cycle %0d",
				name, got, exp, cyc));
		end
	endtask

	task automatic check_garbage(input string name, input netlink_pkg::garbage_t got,
		input netlink_pkg::garbage_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("[FAIL] %s got %h expected %h at cycle %0d",
				name, got, exp, cyc));
		end
	endtask

	task automatic check_count(input string name, input netlink_pkg::frames_cnt_t got,
		input netlink_pkg::frames_cnt_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("[FAIL] %s got %h expected %h at cycle %0d",
				name, got, exp, cyc));
		end
	endtask

	// start bit on all lanes, then lane 0 carries the top byte, msb first
	task automatic send_frame(input netlink_pkg::frame_t f, input logic tracked);
		@(negedge clk);
		{serial_data_0, serial_data_1, serial_data_2, serial_data_3} = 4'hf;
		if (tracked) begin
			frame_start_q.push_back(cyc + 1);
			frame_q.push_back(f);
		end
		for (int i = LANE_BITS - 1; i >= 0; i--) begin
			@(negedge clk);
			serial_data_0 = f[24 + i];
			serial_data_1 = f[16 + i];
			serial_data_2 = f[8 + i];
			serial_data_3 = f[i];
		end
		@(negedge clk);
		{serial_data_0, serial_data_1, serial_data_2, serial_data_3} = 4'h0;
	endtask

	task automatic send_ack(input logic pid, input logic pid_n, input logic seq,
		input logic [31:0] spare);
		@(negedge clk);
		serial_ack = 1'b1;
		ack_start_q.push_back(cyc + 1);
		ack_bits_q.push_back({pid, pid_n, seq});
		@(negedge clk);
		serial_ack = pid;
		@(negedge clk);
		serial_ack = pid_n;
		@(negedge clk);
		serial_ack = seq;
		for (int i = 3; i < ACK_BITS; i++) begin
			@(negedge clk);
			serial_ack = spare[i];
		end
		@(negedge clk);
		serial_ack = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		rst_l = 1'b0;
		link_enable = 1'b0;
		serial_ack = 1'b0;
		{serial_data_0, serial_data_1, serial_data_2, serial_data_3} = 4'h0;
		update_ready = 1'b0;
		repeat (10) @(negedge clk);
		rst_l = 1'b1;
		fork
			begin : data_lanes
				netlink_pkg::frame_t cur;
				netlink_pkg::frame_t f;
				logic [31:0] rs;
				logic tx_seq;
				logic wrong;
				rs = xorshift(SEED);
				tx_seq = 1'b0;
				cur = {tx_seq, rs[30:0]};
				// link still off, receiver stays quiet
				repeat (2) begin
					send_frame(cur, 1'b0);
					repeat (3) @(negedge clk);
				end
				link_enable = 1'b1;
				repeat (2) @(negedge clk);
				for (int n = 0; n < N_SENDS; n++) begin
					rs = xorshift(rs);
					if (rs[7:4] == 4'd0) begin
						link_enable = 1'b0;
						@(negedge clk);
						send_frame(cur, 1'b0);
						link_enable = 1'b1;
						repeat (2) @(negedge clk);
					end
					wrong = (rs[1:0] == 2'd0);
					f = wrong ? {~tx_seq, rs[31:1]} : cur;
					send_frame(f, 1'b1);
					repeat (1 + rs[10:8]) @(negedge clk);
					while (frame_start_q.size() != 0) @(negedge clk);
					// sender moves on only once its frame got in
					if (last_accepted && !wrong) begin
						tx_seq = ~tx_seq;
						rs = xorshift(rs);
						cur = {tx_seq, rs[30:0]};
					end
				end
			end
			begin : ack_lane
				logic [31:0] ra;
				logic [1:0] pids;
				ra = xorshift(SEED ^ 32'h5bd1e995);
				for (int n = 0; n < N_ACKS; n++) begin
					ra = xorshift(ra);
					pids = (ra[1:0] == 2'd0) ? ra[3:2] : 2'b10;
					send_ack(pids[1], pids[0], ra[4], ra);
					repeat (ra[11:9]) @(negedge clk);
				end
			end
		join
		repeat (20) @(negedge clk);
		if (frame_start_q.size() != 0 || ack_start_q.size() != 0) begin
			stop_on_error("frames or acknowledges still outstanding at the end of the run");
		end else if (accepts == 0 || rejects == 0 || drops == 0 || good_acks == 0) begin
			stop_on_error("stimulus never reached accept, reject, drop and ack cases");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

	// game side readiness, long low stretches give back-pressure
	initial begin : ready_pattern
		logic [31:0] rr;
		logic [1:0] mode;
		int hold;
		rr = xorshift(SEED ^ 32'h2545f491);
		wait (rst_l === 1'b1);
		forever begin
			rr = xorshift(rr);
			mode = rr[7:6];
			hold = 1 + int'(rr[5:0]);
			repeat (hold) begin
				@(negedge clk);
				rr = xorshift(rr);
				update_ready = (mode == 2'd0) ? 1'b0 : (mode == 2'd1) ? 1'b1 : rr[0];
			end
		end
	end

	// stepped on each rising edge, compared at the falling edge
	initial begin : model
		logic accept;
		logic ack_exp;
		netlink_pkg::frame_t f;
		logic [2:0] b;
		wait (rst_l === 1'b1);
		forever begin
			@(posedge clk);
			cyc++;
			accept = 1'b0;
			ack_exp = 1'b0;
			if (frame_start_q.size() != 0 && frame_start_q[0] + LANE_BITS + 2 == cyc) begin
				void'(frame_start_q.pop_front());
				f = frame_q.pop_front();
				accept = !m_valid && (f[31] == m_seq);
				if (accept) accepts++;
				else if (f[31] != m_seq) rejects++;
				else drops++;
				last_accepted = accept;
			end
			if (accept) begin
				m_valid = 1'b1;
				m_frame = f;
				m_loaded = 1'b1;
				m_ack_seq = f[31];
				m_seq = ~m_seq;
				m_count = m_count + 1'b1;
			end else if (m_valid && update_ready) begin
				m_valid = 1'b0;
			end
			// result one edge after the last ack bit
			if (ack_start_q.size() != 0 && ack_start_q[0] + ACK_BITS + 1 == cyc) begin
				void'(ack_start_q.pop_front());
				b = ack_bits_q.pop_front();
				if (b[2] && !b[1]) begin
					ack_exp = 1'b1;
					m_rx_seq = b[0];
					good_acks++;
				end
			end
			@(negedge clk);
			check_bit("update_valid", update_valid, m_valid);
			check_bit("ack_send", ack_send, accept);
			check_bit("ack_seq", ack_seq, m_ack_seq);
			check_count("frames_accepted", frames_accepted, m_count);
			check_bit("ack_received", ack_received, ack_exp);
			check_bit("ack_rx_seq", ack_rx_seq, m_rx_seq);
			// fields are undefined until the first accepted frame
			if (m_loaded) begin
				check_garbage("opp_garbage", opp_garbage, m_frame[30:28]);
				check_tile("opp_hold", opp_hold, m_frame[27:24]);
				for (int k = 0; k < 6; k++) begin
					check_tile($sformatf("opp_queue_%0d", k), opp_queue[k],
						m_frame[23 - 4 * k -: 4]);
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		stop_on_error("watchdog expired before all frames and acknowledges were sent");
	end

endmodule

`default_nettype wire

// File: netlink_rx.f
source/netlink_pkg.sv
source/lane_deserializer.sv
source/bit_counter.sv
source/frame_sequencer.sv
source/frame_checker.sv
source/ack_decoder.sv
source/netlink_rx.sv
test/netlink_rx_sva.sv
test/netlink_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the netlink_rx testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module netlink_rx_tb -f netlink_rx.f
./obj_dir/Vnetlink_rx_tb
